/* common/cfg_bus_if.sv */
////////////////////////////////////////////////////////////
// Internal config bus
// Request/grant/rvalid link from the decoder to a target
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface cfg_bus_if
  import cfg_bus_pkg::*;
  ();

  // Request side, driven by the decoder
  logic       req;
  logic       we;
  cfg_index_t index;
  cfg_data_t  wdata;

  // Response side, driven by the target
  // Grant and read data come back in the request cycle
  logic       gnt;
  cfg_data_t  rdata;
  logic       rvalid;

  modport ctrl (
    output req,
    output we,
    output index,
    output wdata,
    input  gnt,
    input  rdata,
    input  rvalid
  );

  modport target (
    input  req,
    input  we,
    input  index,
    input  wdata,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface : cfg_bus_if

/* common/cfg_bus_pkg.sv */
////////////////////////////////////////////////////////////
// Configuration bus package
// Address and data widths, target codes and decoder states
////////////////////////////////////////////////////////////

package cfg_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  // Configuration address as seen on the SoC port
  typedef logic [15:0] cfg_addr_t;

  // Write and read data word
  typedef logic [31:0] cfg_data_t;

  // Register index, taken from address bits 5:2
  typedef logic [3:0] cfg_index_t;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Target field in address bits 15:12
  // Only the pad registers are present, other codes read as unmapped
  typedef enum logic [3:0] {
    TARGET_PAD     = 4'd0,
    TARGET_HDACC   = 4'd1,
    TARGET_SPIM    = 4'd2,
    TARGET_PREPROC = 4'd3
  } cfg_target_e;

  // Read word returned for any unmapped address
  localparam cfg_data_t CFG_ERR_RDATA = 32'hdeadda7a;

  // Handshake FSM of the decoder
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACCESS = 2'd1,
    ACK    = 2'd2
  } cfg_state_e;

endpackage : cfg_bus_pkg

/* common/pad_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// Pad configuration package
// Pad record, pad counts, pinout and reset values
////////////////////////////////////////////////////////////

package pad_cfg_pkg;

  // Pads on the chip and pads with a config register
  localparam int unsigned NR_PADS     = 12;
  localparam int unsigned NR_CFG_PADS = 9;

  // SPI lanes, data and chip select alike
  localparam int unsigned NR_SPI_LANES = 4;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [1:0] pad_drv_t;

  // One pad setting, rxen in the MSB
  typedef struct packed {
    logic     rxen;
    logic     trien;
    pad_drv_t drv;
    logic     puen;
    logic     pden;
  } pad_cfg_t;

  // One bit per pad
  typedef logic [NR_PADS-1:0] pad_vec_t;

  // Two drive bits per pad, pad n at bits 2n+1:2n
  typedef logic [2*NR_PADS-1:0] pad_drv_vec_t;

  typedef logic [NR_SPI_LANES-1:0] spi_lane_t;

  ////////////////////////////////////////////////////////////
  // Pinout
  ////////////////////////////////////////////////////////////

  localparam int unsigned PAD_EXT_CLK    = 0;
  localparam int unsigned PAD_BYPASS_CLK = 1;
  localparam int unsigned PAD_SPI_CLK    = 2;
  localparam int unsigned PAD_SDIO_BASE  = 3;
  localparam int unsigned PAD_CSN_BASE   = 7;
  localparam int unsigned PAD_UNUSED     = 11;

  // Register that configures each pad group
  localparam int unsigned REG_SPI_CLK   = 0;
  localparam int unsigned REG_SDIO_BASE = 1;
  localparam int unsigned REG_CSN_BASE  = 5;

  // Pad tristated, receiver off, no pulls
  localparam pad_cfg_t PAD_CFG_RESET = '{
    rxen:  1'b0,
    trien: 1'b1,
    drv:   2'b00,
    puen:  1'b0,
    pden:  1'b0
  };

endpackage : pad_cfg_pkg

/* hdl/cfg_decode.sv */
////////////////////////////////////////////////////////////
// Config port decoder
// Four-phase SoC handshake and routing onto the pad bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cfg_decode
  import cfg_bus_pkg::*;
  import pad_cfg_pkg::*;
  (
  input  logic      sys_clk,
  input  logic      rst_ni,
  // SoC side
  input  logic      cfg_req_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  cfg_data_t cfg_wdata_i,
  output cfg_data_t cfg_rdata_o,
  output logic      cfg_ack_o,
  // Pad register side
  cfg_bus_if.ctrl   bus
);

  cfg_state_e  state_q, state_d;
  cfg_target_e target;
  cfg_index_t  index;
  logic        legal;
  logic        ack_q;
  cfg_data_t   rdata_q;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign target = cfg_target_e'(cfg_addr_i[15:12]);
  assign index  = cfg_addr_i[5:2];

  // Only pad target with an existing register
  assign legal = (target == TARGET_PAD) && (index < NR_CFG_PADS);

  // SoC holds address and data stable during the request
  // One bus cycle, in ACCESS only, unmapped never reaches the bus
  assign bus.req   = (state_q == ACCESS) && legal;
  assign bus.we    = cfg_we_i;
  assign bus.index = index;
  assign bus.wdata = cfg_wdata_i;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (cfg_req_i) state_d = ACCESS;
      ACCESS:  state_d = ACK;
      // Held request only stretches the ack phase
      ACK:     if (!cfg_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      // Ack rises at the end of the bus cycle
      if (state_q == ACCESS) begin
        ack_q <= 1'b1;
      end else if (state_q == ACK && !cfg_req_i) begin
        ack_q <= 1'b0;
      end
      // Capture read data, error word for unmapped reads
      if (bus.rvalid) begin
        rdata_q <= bus.rdata;
      end else if (state_q == ACCESS && !cfg_we_i) begin
        rdata_q <= CFG_ERR_RDATA;
      end
    end
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Target must answer in the request cycle
  a_req_gnt : assert property (@(posedge sys_clk) disable iff (!rst_ni)
    bus.req |-> bus.gnt);

  a_ack_state : assert property (@(posedge sys_clk) disable iff (!rst_ni)
    cfg_ack_o |-> state_q == ACK);

  // Read word holds for the whole ack phase
  a_rdata_stable : assert property (@(posedge sys_clk) disable iff (!rst_ni)
    cfg_ack_o |=> !cfg_ack_o || $stable(cfg_rdata_o));

endmodule : cfg_decode

/* hdl/pad_ctrl_top.sv */
////////////////////////////////////////////////////////////
// Pad control top level
// Config port, pad registers and pad drive map
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_ctrl_top
  import cfg_bus_pkg::*;
  import pad_cfg_pkg::*;
  (
  input  logic         sys_clk,
  input  logic         rst_ni,
  // SoC configuration port, four-phase handshake
  input  logic         cfg_req_i,
  input  logic         cfg_we_i,
  input  cfg_addr_t    cfg_addr_i,
  input  cfg_data_t    cfg_wdata_i,
  output cfg_data_t    cfg_rdata_o,
  output logic         cfg_ack_o,
  // SPI master pins
  input  logic         spi_clk_i,
  input  spi_lane_t    spi_csn_i,
  input  spi_lane_t    spi_sdo_i,
  input  spi_lane_t    spi_oen_i,
  output spi_lane_t    spi_sdi_o,
  // Exported clock pins
  output logic         ext_clk_o,
  output logic         bypass_clk_o,
  // IO pads
  input  pad_vec_t     io_y_i,
  output pad_vec_t     io_data_o,
  output pad_vec_t     io_rxen_o,
  output pad_vec_t     io_trien_o,
  output pad_vec_t     io_puen_o,
  output pad_vec_t     io_pden_o,
  output pad_drv_vec_t io_drv_o
);

  // Decoder to register file
  cfg_bus_if cfg_bus ();

  // Register file to drive map
  pad_cfg_t pad_cfg [NR_CFG_PADS];

  cfg_decode i_cfg_decode (
    .sys_clk     (sys_clk),
    .rst_ni      (rst_ni),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .cfg_ack_o   (cfg_ack_o),
    .bus         (cfg_bus.ctrl)
  );

  pad_cfg_regs i_pad_cfg_regs (
    .sys_clk   (sys_clk),
    .rst_ni    (rst_ni),
    .bus       (cfg_bus.target),
    .pad_cfg_o (pad_cfg)
  );

  pad_drive_map i_pad_drive_map (
    .pad_cfg_i    (pad_cfg),
    .spi_clk_i    (spi_clk_i),
    .spi_csn_i    (spi_csn_i),
    .spi_sdo_i    (spi_sdo_i),
    .spi_oen_i    (spi_oen_i),
    .spi_sdi_o    (spi_sdi_o),
    .ext_clk_o    (ext_clk_o),
    .bypass_clk_o (bypass_clk_o),
    .io_y_i       (io_y_i),
    .io_data_o    (io_data_o),
    .io_rxen_o    (io_rxen_o),
    .io_trien_o   (io_trien_o),
    .io_puen_o    (io_puen_o),
    .io_pden_o    (io_pden_o),
    .io_drv_o     (io_drv_o)
  );

endmodule : pad_ctrl_top

/* pad_ctrl.f */
common/cfg_bus_pkg.sv
common/pad_cfg_pkg.sv
common/cfg_bus_if.sv
hdl/cfg_decode.sv
pad_ctrl/pad_cfg_regs.sv
pad_ctrl/pad_drive_map.sv
hdl/pad_ctrl_top.sv
sim/tb_pad_ctrl.sv

/* pad_ctrl/pad_cfg_regs.sv */
////////////////////////////////////////////////////////////
// Pad configuration registers
// Nine pad records with write and zero-extended readback
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_cfg_regs
  import cfg_bus_pkg::*;
  import pad_cfg_pkg::*;
  (
  input  logic      sys_clk,
  input  logic      rst_ni,
  // Config bus from the decoder
  cfg_bus_if.target bus,
  // Register contents for the drive map
  output pad_cfg_t  pad_cfg_o [NR_CFG_PADS]
);

  // Zero padding above a record in the read word
  localparam int unsigned PAD_BITS = $bits(pad_cfg_t);
  localparam int unsigned FILL_BITS = $bits(cfg_data_t) - PAD_BITS;

  pad_cfg_t pad_cfg_q [NR_CFG_PADS];
  logic     wr_en;
  logic     rd_en;

  ////////////////////////////////////////////////////////////
  // Bus response
  ////////////////////////////////////////////////////////////

  assign wr_en = bus.req && bus.we;
  assign rd_en = bus.req && !bus.we;

  // Every request is taken at once
  assign bus.gnt    = bus.req;
  assign bus.rvalid = rd_en;

  always_comb begin
    bus.rdata = '0;
    if (rd_en) begin
      // Record in bits 5:0, zeros above
      bus.rdata = {{FILL_BITS{1'b0}}, pad_cfg_q[bus.index]};
    end
  end

  ////////////////////////////////////////////////////////////
  // Register array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NR_CFG_PADS; i++) begin
        pad_cfg_q[i] <= PAD_CFG_RESET;
      end
    end else if (wr_en) begin
      // Only the low six bits of the write word are kept
      pad_cfg_q[bus.index] <= pad_cfg_t'(bus.wdata[PAD_BITS-1:0]);
    end
  end

  assign pad_cfg_o = pad_cfg_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Decoder filters out indices past the last register
  a_index_range : assert property (@(posedge sys_clk) disable iff (!rst_ni)
    bus.req |-> bus.index < NR_CFG_PADS);

endmodule : pad_cfg_regs

/* pad_ctrl/pad_drive_map.sv */
////////////////////////////////////////////////////////////
// Pad drive map
// Pad control vectors from register records and SPI pins
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_drive_map
  import pad_cfg_pkg::*;
  (
  // Register contents
  input  pad_cfg_t     pad_cfg_i [NR_CFG_PADS],
  // SPI master pins
  input  logic         spi_clk_i,
  input  spi_lane_t    spi_csn_i,
  input  spi_lane_t    spi_sdo_i,
  input  spi_lane_t    spi_oen_i,
  output spi_lane_t    spi_sdi_o,
  // Clock pins exported from pads 0 and 1
  output logic         ext_clk_o,
  output logic         bypass_clk_o,
  // IO pads
  input  pad_vec_t     io_y_i,
  output pad_vec_t     io_data_o,
  output pad_vec_t     io_rxen_o,
  output pad_vec_t     io_trien_o,
  output pad_vec_t     io_puen_o,
  output pad_vec_t     io_pden_o,
  output pad_drv_vec_t io_drv_o
);

  always_comb begin
    int unsigned pad;

    // Everything off by default
    io_data_o  = '0;
    io_rxen_o  = '0;
    io_trien_o = '0;
    io_puen_o  = '0;
    io_pden_o  = '0;
    io_drv_o   = '0;

    ////////////////////////////////////////////////////////////
    // Static pads
    ////////////////////////////////////////////////////////////

    // Clock inputs, receiver on, driver tristated
    io_rxen_o[PAD_EXT_CLK]     = 1'b1;
    io_trien_o[PAD_EXT_CLK]    = 1'b1;
    io_rxen_o[PAD_BYPASS_CLK]  = 1'b1;
    io_trien_o[PAD_BYPASS_CLK] = 1'b1;

    // Spare pad, fully off
    io_trien_o[PAD_UNUSED] = 1'b1;

    ////////////////////////////////////////////////////////////
    // Configurable pads
    ////////////////////////////////////////////////////////////

    // Drive and pulls come straight from the record
    for (int unsigned r = 0; r < NR_CFG_PADS; r++) begin
      pad = r + PAD_SPI_CLK - REG_SPI_CLK;
      io_drv_o[2*pad +: 2] = pad_cfg_i[r].drv;
      io_puen_o[pad]       = pad_cfg_i[r].puen;
      io_pden_o[pad]       = pad_cfg_i[r].pden;
    end

    // SPI clock
    io_data_o[PAD_SPI_CLK]  = spi_clk_i;
    io_rxen_o[PAD_SPI_CLK]  = pad_cfg_i[REG_SPI_CLK].rxen;
    io_trien_o[PAD_SPI_CLK] = pad_cfg_i[REG_SPI_CLK].trien;

    for (int unsigned l = 0; l < NR_SPI_LANES; l++) begin
      // Data lanes follow the master's output enable
      // Needs rxen 1 and trien 0 in the record for lane switching
      io_data_o[PAD_SDIO_BASE+l]  = spi_sdo_i[l];
      io_rxen_o[PAD_SDIO_BASE+l]  = spi_oen_i[l] & pad_cfg_i[REG_SDIO_BASE+l].rxen;
      io_trien_o[PAD_SDIO_BASE+l] = spi_oen_i[l] & ~pad_cfg_i[REG_SDIO_BASE+l].trien;

      // Chip selects, as stored
      io_data_o[PAD_CSN_BASE+l]  = spi_csn_i[l];
      io_rxen_o[PAD_CSN_BASE+l]  = pad_cfg_i[REG_CSN_BASE+l].rxen;
      io_trien_o[PAD_CSN_BASE+l] = pad_cfg_i[REG_CSN_BASE+l].trien;
    end
  end

  ////////////////////////////////////////////////////////////
  // Inputs from the pads
  ////////////////////////////////////////////////////////////

  assign spi_sdi_o    = io_y_i[PAD_SDIO_BASE +: NR_SPI_LANES];
  assign ext_clk_o    = io_y_i[PAD_EXT_CLK];
  assign bypass_clk_o = io_y_i[PAD_BYPASS_CLK];

endmodule : pad_drive_map

/* run_sim.sh */
#!/bin/sh
# Builds the pad control testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pad_ctrl -f pad_ctrl.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pad_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench reports it
echo "$out" | grep -q "Simulation finished: PASS"
if [ $? -ne 0 ]; then
  exit 1
fi
exit 0

/* sim/tb_pad_ctrl.sv */
////////////////////////////////////////////////////////////
// Pad control testbench
// Drives the config port and SPI pins and checks against a model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pad_ctrl
  import cfg_bus_pkg::*;
  import pad_cfg_pkg::*;
  ();

  localparam int ACK_TIMEOUT = 20;

  // Expected pad side of the DUT
  typedef struct packed {
    spi_lane_t    sdi;
    logic         ext_clk;
    logic         bypass_clk;
    pad_vec_t     data;
    pad_vec_t     rxen;
    pad_vec_t     trien;
    pad_vec_t     puen;
    pad_vec_t     pden;
    pad_drv_vec_t drv;
  } pad_exp_t;

  logic         sys_clk;
  logic         rst_ni;
  logic         cfg_req_i;
  logic         cfg_we_i;
  cfg_addr_t    cfg_addr_i;
  cfg_data_t    cfg_wdata_i;
  cfg_data_t    cfg_rdata_o;
  logic         cfg_ack_o;
  logic         spi_clk_i;
  spi_lane_t    spi_csn_i;
  spi_lane_t    spi_sdo_i;
  spi_lane_t    spi_oen_i;
  spi_lane_t    spi_sdi_o;
  logic         ext_clk_o;
  logic         bypass_clk_o;
  pad_vec_t     io_y_i;
  pad_vec_t     io_data_o;
  pad_vec_t     io_rxen_o;
  pad_vec_t     io_trien_o;
  pad_vec_t     io_puen_o;
  pad_vec_t     io_pden_o;
  pad_drv_vec_t io_drv_o;

  // Model state and bookkeeping
  pad_cfg_t    ref_regs [NR_CFG_PADS];
  pad_exp_t    exp_pads;
  logic [31:0] rng_state;
  logic        cmp_en;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  string       test_name;

  pad_ctrl_top dut (.*);

  initial sys_clk = 1'b0;
  always #2 sys_clk = ~sys_clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // LCG with the numerical recipes constants
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic cfg_addr_t make_addr(input logic [3:0] target, input logic [3:0] index);
    logic [31:0] r;
    r = next_rand();
    // Bits 11:6 and 1:0 are not decoded
    return {target, r[11:6], index, r[1:0]};
  endfunction

  function automatic logic is_legal(input cfg_addr_t addr);
    return (addr[15:12] == 4'(TARGET_PAD)) && (addr[5:2] < 4'(NR_CFG_PADS));
  endfunction

  // Read word of the register map
  function automatic cfg_data_t ref_read(input cfg_addr_t addr);
    if (is_legal(addr)) begin
      return {26'd0, ref_regs[addr[5:2]]};
    end
    return CFG_ERR_RDATA;
  endfunction

  // Pad map from the chip pinout
  function automatic pad_exp_t ref_pads(input pad_cfg_t regs [NR_CFG_PADS], input logic clk,
                                        input spi_lane_t csn, input spi_lane_t sdo,
                                        input spi_lane_t oen, input pad_vec_t y);
    pad_exp_t e;
    pad_cfg_t c;
    e = '0;
    // Clock inputs on pads 0 and 1 and the spare pad 11
    e.rxen[0]   = 1'b1;
    e.trien[0]  = 1'b1;
    e.rxen[1]   = 1'b1;
    e.trien[1]  = 1'b1;
    e.trien[11] = 1'b1;
    for (int p = 2; p <= 10; p++) begin
      c = regs[p-2];
      e.drv[2*p +: 2] = c.drv;
      e.puen[p]       = c.puen;
      e.pden[p]       = c.pden;
      if (p == 2) begin
        e.data[p]  = clk;
        e.rxen[p]  = c.rxen;
        e.trien[p] = c.trien;
      end else if (p <= 6) begin
        // Data pads gated by the lane output enable
        e.data[p]  = sdo[p-3];
        e.rxen[p]  = oen[p-3] & c.rxen;
        e.trien[p] = oen[p-3] & ~c.trien;
      end else begin
        e.data[p]  = csn[p-7];
        e.rxen[p]  = c.rxen;
        e.trien[p] = c.trien;
      end
    end
    e.sdi        = y[6:3];
    e.ext_clk    = y[0];
    e.bypass_clk = y[1];
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR at %0t: %s", $time, reason);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("TEST %s: %0d checks, %0d errors", test_name,
             checks - test_checks, errors - test_errors);
  endtask

  task automatic next_cycle();
    @(posedge sys_clk);
    #0.5;
  endtask

  // One four-phase access with the request held hold extra cycles past the ack
  task automatic cfg_access(input logic we, input cfg_addr_t addr, input cfg_data_t wdata,
                            input int hold, output cfg_data_t rdata,
                            output int rise_edges, output int fall_edges);
    int n;
    cfg_req_i   = 1'b1;
    cfg_we_i    = we;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    n = 0;
    do begin
      next_cycle();
      n++;
      if (n > ACK_TIMEOUT) abort_run("cfg_ack_o never rose for a configuration access");
    end while (!cfg_ack_o);
    rise_edges = n;
    rdata      = cfg_rdata_o;
    // Write lands on the same edge as the ack
    if (we && is_legal(addr)) begin
      ref_regs[addr[5:2]] = pad_cfg_t'(wdata[5:0]);
    end
    for (int i = 0; i < hold; i++) begin
      next_cycle();
      check_value("cfg_ack_o", 32'(cfg_ack_o), 32'd1);
      check_value("cfg_rdata_o", cfg_rdata_o, rdata);
    end
    cfg_req_i = 1'b0;
    n = 0;
    do begin
      next_cycle();
      n++;
      if (n > ACK_TIMEOUT) abort_run("cfg_ack_o never fell after the request dropped");
    end while (cfg_ack_o);
    fall_edges = n;
  endtask

  task automatic write_reg(input cfg_addr_t addr, input cfg_data_t wdata);
    cfg_data_t rd;
    int        rise;
    int        fall;
    cfg_access(1'b1, addr, wdata, 0, rd, rise, fall);
  endtask

  task automatic read_check(input cfg_addr_t addr);
    cfg_data_t rd;
    cfg_data_t exp;
    int        rise;
    int        fall;
    exp = ref_read(addr);
    cfg_access(1'b0, addr, '0, 0, rd, rise, fall);
    check_value("cfg_rdata_o", rd, exp);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < NR_CFG_PADS; i++) begin
      read_check(make_addr(4'(TARGET_PAD), 4'(i)));
    end
  endtask

  task automatic randomize_pins();
    logic [31:0] r;
    r = next_rand();
    spi_clk_i = r[0];
    spi_csn_i = r[4:1];
    spi_sdo_i = r[8:5];
    spi_oen_i = r[12:9];
    io_y_i    = r[24:13];
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process for the pad side
  ////////////////////////////////////////////////////////////

  always @(negedge sys_clk) begin
    if (cmp_en) begin
      exp_pads = ref_pads(ref_regs, spi_clk_i, spi_csn_i, spi_sdo_i, spi_oen_i, io_y_i);
      check_value("io_data_o", 32'(io_data_o), 32'(exp_pads.data));
      check_value("io_rxen_o", 32'(io_rxen_o), 32'(exp_pads.rxen));
      check_value("io_trien_o", 32'(io_trien_o), 32'(exp_pads.trien));
      check_value("io_puen_o", 32'(io_puen_o), 32'(exp_pads.puen));
      check_value("io_pden_o", 32'(io_pden_o), 32'(exp_pads.pden));
      check_value("io_drv_o", 32'(io_drv_o), 32'(exp_pads.drv));
      check_value("spi_sdi_o", 32'(spi_sdi_o), 32'(exp_pads.sdi));
      check_value("ext_clk_o", 32'(ext_clk_o), 32'(exp_pads.ext_clk));
      check_value("bypass_clk_o", 32'(bypass_clk_o), 32'(exp_pads.bypass_clk));
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    cfg_data_t rd;
    cfg_data_t exp;
    cfg_addr_t addr;
    int        rise;
    int        fall;
    int        hold;

    rst_ni      = 1'b0;
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    spi_clk_i   = 1'b0;
    spi_csn_i   = '0;
    spi_sdo_i   = '0;
    spi_oen_i   = '0;
    io_y_i      = '0;
    cmp_en      = 1'b0;
    checks      = 0;
    errors      = 0;
    rng_state   = 32'h4b444e70;
    for (int i = 0; i < NR_CFG_PADS; i++) begin
      ref_regs[i] = PAD_CFG_RESET;
    end

    repeat (16) @(posedge sys_clk);
    #0.5;
    rst_ni = 1'b1;
    cmp_en = 1'b1;

    begin_test("after_reset");
    check_value("cfg_ack_o", 32'(cfg_ack_o), 32'd0);
    check_value("cfg_rdata_o", cfg_rdata_o, 32'd0);
    randomize_pins();
    read_all_regs();
    end_test();

    begin_test("write_read");
    for (int i = 0; i < NR_CFG_PADS; i++) begin
      write_reg(make_addr(4'(TARGET_PAD), 4'(i)), next_rand());
    end
    read_all_regs();
    end_test();

    begin_test("unmapped");
    for (int i = NR_CFG_PADS; i < 16; i++) begin
      addr = make_addr(4'(TARGET_PAD), 4'(i));
      write_reg(addr, next_rand());
      read_check(addr);
    end
    for (int t = 1; t < 16; t++) begin
      addr = make_addr(4'(t), 4'(next_rand() % 32'd16));
      write_reg(addr, next_rand());
      read_check(addr);
    end
    // Nothing above may have touched a register
    read_all_regs();
    end_test();

    begin_test("handshake");
    for (int k = 0; k < 8; k++) begin
      addr = make_addr(4'(TARGET_PAD), 4'(next_rand() % 32'd9));
      hold = 1 + int'(next_rand() % 32'd5);
      exp  = ref_read(addr);
      cfg_access(k[0], addr, next_rand(), hold, rd, rise, fall);
      check_value("ack_rise_edges", 32'(rise), 32'd2);
      check_value("ack_fall_edges", 32'(fall), 32'd1);
      if (!k[0]) begin
        check_value("cfg_rdata_o", rd, exp);
      end
      // A held request must not start a second access
      repeat (2) begin
        next_cycle();
        check_value("cfg_ack_o", 32'(cfg_ack_o), 32'd0);
      end
    end
    read_all_regs();
    end_test();

    begin_test("pad_mapping");
    for (int k = 0; k < 24; k++) begin
      write_reg(make_addr(4'(TARGET_PAD), 4'(next_rand() % 32'd9)), next_rand());
      for (int j = 0; j < 3; j++) begin
        randomize_pins();
        next_cycle();
      end
    end
    read_all_regs();
    end_test();

    cmp_en = 1'b0;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_pad_ctrl
